/* verilog/muldiv_cfg.svh */
// ------------------------------
// Widths and depth of the mul/div pipeline
// MULDIV_RESULT_STAGES must be 1 or more
// ------------------------------

`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// Operand width in bits
`define MULDIV_XLEN 32

// Result delay registers after the arithmetic stage
`define MULDIV_RESULT_STAGES 2

// Edges from request accept to resp_val, no stalls
// Request reg, operand reg, result reg, then the delay chain
`define MULDIV_LATENCY (2 + `MULDIV_RESULT_STAGES)

`endif

/* verilog/muldiv_req_pkg.sv */
// ------------------------------
// Request side types of the mul/div unit
// Codes 5 to 7 are invalid and give a zero result
// ------------------------------

`include "muldiv_cfg.svh"

package muldiv_req_pkg;

  // Function codes
  typedef enum logic [2:0] {
    MUL  = 3'd0,
    DIV  = 3'd1,
    DIVU = 3'd2,
    REM  = 3'd3,
    REMU = 3'd4
  } fn_e;

  // Raw request as it enters the unit
  typedef struct packed {
    fn_e                    fn;
    logic [`MULDIV_XLEN-1:0] a;
    logic [`MULDIV_XLEN-1:0] b;
  } req_t;

  // Conditioned operands, special cases already decided
  typedef struct packed {
    fn_e                     fn;
    logic [`MULDIV_XLEN-1:0] mag_a;
    logic [`MULDIV_XLEN-1:0] mag_b;
    logic                    neg_q;    // negate product or quotient
    logic                    neg_r;    // negate remainder
    logic                    div_zero;
    logic                    ovf;
    logic                    bad_fn;
    logic [`MULDIV_XLEN-1:0] dividend;
  } opnd_t;

endpackage

/* verilog/muldiv_resp_pkg.sv */
// ------------------------------
// Response side types, 2*XLEN result
// ------------------------------

`include "muldiv_cfg.svh"

package muldiv_resp_pkg;

  // Packed result, hi is the upper half
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] hi;
    logic [`MULDIV_XLEN-1:0] lo;
  } result_t;

  // Remainder high, quotient low
  function automatic result_t pack_divrem(input logic [`MULDIV_XLEN-1:0] rem,
                                          input logic [`MULDIV_XLEN-1:0] quo);
    result_t res;
    res.hi = rem;
    res.lo = quo;
    return res;
  endfunction

  // Full product split into halves
  function automatic result_t pack_prod(input logic [2*`MULDIV_XLEN-1:0] prod);
    result_t res;
    res.hi = prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
    res.lo = prod[`MULDIV_XLEN-1:0];
    return res;
  endfunction

endpackage

/* verilog/muldiv_pipe_reg.sv */
// ------------------------------
// One pipeline stage register
// hold freezes valid and payload together
// ------------------------------

`timescale 1ns/1ps

module muldiv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     in_val,
  input  payload_t in_data,
  output logic     out_val,
  output payload_t out_data
);

  // ------------------------------
  // Valid bit
  // ------------------------------

  // Only the valid bit sees reset
  always_ff @(posedge clk) begin
    if (!reset) begin
      out_val <= 1'b0;
    end else if (!hold) begin
      out_val <= in_val;
    end
  end

  // ------------------------------
  // Payload
  // ------------------------------

  // Bubbles load junk payload, valid tells them apart
  always_ff @(posedge clk) begin
    if (!hold) begin
      out_data <= in_data;
    end
  end

endmodule

/* verilog/muldiv_opnd_prep.sv */
// ------------------------------
// Operand conditioning, purely combinational
// Special cases are decided here and only here
// ------------------------------

`timescale 1ns/1ps

`include "muldiv_cfg.svh"

module muldiv_opnd_prep (
  input  muldiv_req_pkg::req_t  in_data,
  output muldiv_req_pkg::opnd_t out_data
);

  localparam int xlen = `MULDIV_XLEN;

  // Most negative signed value
  localparam logic [xlen-1:0] min_int = {1'b1, {(xlen-1){1'b0}}};

  logic is_signed;
  logic is_sdiv;
  logic is_div;
  logic is_known;
  logic sign_a;
  logic sign_b;

  // ------------------------------
  // Function decode
  // ------------------------------

  always_comb begin
    // MUL runs on magnitudes too
    is_sdiv   = (in_data.fn == muldiv_req_pkg::DIV) ||
                (in_data.fn == muldiv_req_pkg::REM);
    is_signed = is_sdiv || (in_data.fn == muldiv_req_pkg::MUL);
    is_div    = is_sdiv ||
                (in_data.fn == muldiv_req_pkg::DIVU) ||
                (in_data.fn == muldiv_req_pkg::REMU);
    is_known  = is_div || (in_data.fn == muldiv_req_pkg::MUL);
  end

  // ------------------------------
  // Magnitudes and signs
  // ------------------------------

  always_comb begin
    // Operand signs count only for signed functions
    sign_a = is_signed && in_data.a[xlen-1];
    sign_b = is_signed && in_data.b[xlen-1];

    out_data.fn    = in_data.fn;
    // Abs of min_int wraps to 2^(xlen-1), still right as unsigned
    out_data.mag_a = sign_a ? (~in_data.a + 1'b1) : in_data.a;
    out_data.mag_b = sign_b ? (~in_data.b + 1'b1) : in_data.b;

    // Quotient and product sign from both operands
    out_data.neg_q = sign_a ^ sign_b;
    // Remainder follows the dividend
    out_data.neg_r = sign_a && is_sdiv;

    // Special cases
    out_data.div_zero = is_div && (in_data.b == '0);
    out_data.ovf      = is_sdiv && (in_data.a == min_int) && (in_data.b == '1);
    out_data.bad_fn   = !is_known;

    // Raw dividend, needed for div by zero and overflow
    out_data.dividend = in_data.a;
  end

endmodule

/* verilog/muldiv_arith.sv */
// ------------------------------
// Multiply and divide on magnitudes, combinational
// Divider gets a dummy divisor of 1 on divide by zero
// ------------------------------

`timescale 1ns/1ps

`include "muldiv_cfg.svh"

module muldiv_arith (
  input  muldiv_req_pkg::opnd_t   in_data,
  output muldiv_resp_pkg::result_t out_data
);

  localparam int xlen = `MULDIV_XLEN;

  logic [2*xlen-1:0] prod_mag;
  logic [2*xlen-1:0] prod;
  logic [xlen-1:0]   divisor;
  logic [xlen-1:0]   quo_mag;
  logic [xlen-1:0]   rem_mag;
  logic [xlen-1:0]   quo;
  logic [xlen-1:0]   rem;

  // ------------------------------
  // Unsigned core
  // ------------------------------

  always_comb begin
    // Full width product of the magnitudes
    prod_mag = {{xlen{1'b0}}, in_data.mag_a} * {{xlen{1'b0}}, in_data.mag_b};

    // Keep the divider away from zero, result replaced below
    divisor = in_data.div_zero ? {{(xlen-1){1'b0}}, 1'b1} : in_data.mag_b;
    quo_mag = in_data.mag_a / divisor;
    rem_mag = in_data.mag_a % divisor;
  end

  // ------------------------------
  // Sign fix-up and special cases
  // ------------------------------

  always_comb begin
    prod = in_data.neg_q ? (~prod_mag + 1'b1) : prod_mag;
    quo  = in_data.neg_q ? (~quo_mag + 1'b1) : quo_mag;
    rem  = in_data.neg_r ? (~rem_mag + 1'b1) : rem_mag;

    // RISC-V divide by zero
    if (in_data.div_zero) begin
      quo = '1;
      rem = in_data.dividend;
    end else if (in_data.ovf) begin
      // min_int / -1
      quo = in_data.dividend;
      rem = '0;
    end
  end

  // ------------------------------
  // Result select
  // ------------------------------

  always_comb begin
    if (in_data.bad_fn) begin
      out_data = '0;
    end else if (in_data.fn == muldiv_req_pkg::MUL) begin
      out_data = muldiv_resp_pkg::pack_prod(prod);
    end else begin
      // DIV, DIVU, REM, REMU share one packing
      out_data = muldiv_resp_pkg::pack_divrem(rem, quo);
    end
  end

endmodule

/* verilog/muldiv_pipe.sv */
// ------------------------------
// Pipelined mul/div, in order, one result per request
// Output back-pressure freezes every stage, bubbles stay
// ------------------------------

`timescale 1ns/1ps

`include "muldiv_cfg.svh"

module muldiv_pipe (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_req_pkg::fn_e      req_fn,
  input  logic [`MULDIV_XLEN-1:0]  req_a,
  input  logic [`MULDIV_XLEN-1:0]  req_b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_resp_pkg::result_t resp_result
);

  localparam int n_delay = `MULDIV_RESULT_STAGES;

  logic stall;

  // Stage links
  muldiv_req_pkg::req_t     req_in;
  muldiv_req_pkg::req_t     req_q;
  logic                     req_q_val;
  muldiv_req_pkg::opnd_t    opnd_d;
  muldiv_req_pkg::opnd_t    opnd_q;
  logic                     opnd_q_val;
  muldiv_resp_pkg::result_t arith_res;

  // Index 0 is the first result reg, last entry drives the output
  muldiv_resp_pkg::result_t res_data [n_delay+1];
  logic                     res_val  [n_delay+1];

  // ------------------------------
  // Handshake and global stall
  // ------------------------------

  // Held output blocks everything behind it
  assign stall   = resp_val && !resp_rdy;
  assign req_rdy = !stall;

  always_comb begin
    req_in.fn = req_fn;
    req_in.a  = req_a;
    req_in.b  = req_b;
  end

  // ------------------------------
  // Request and operand stages
  // ------------------------------

  // req_val loads straight in, accept only happens when not stalled
  muldiv_pipe_reg #(.payload_t(muldiv_req_pkg::req_t)) i_req_reg (
    .clk(clk), .reset(reset), .hold(stall),
    .in_val(req_val), .in_data(req_in),
    .out_val(req_q_val), .out_data(req_q)
  );

  muldiv_opnd_prep i_opnd_prep (.in_data(req_q), .out_data(opnd_d));

  muldiv_pipe_reg #(.payload_t(muldiv_req_pkg::opnd_t)) i_opnd_reg (
    .clk(clk), .reset(reset), .hold(stall),
    .in_val(req_q_val), .in_data(opnd_d),
    .out_val(opnd_q_val), .out_data(opnd_q)
  );

  // ------------------------------
  // Arithmetic and result chain
  // ------------------------------

  muldiv_arith i_arith (.in_data(opnd_q), .out_data(arith_res));

  muldiv_pipe_reg #(.payload_t(muldiv_resp_pkg::result_t)) i_res_reg (
    .clk(clk), .reset(reset), .hold(stall),
    .in_val(opnd_q_val), .in_data(arith_res),
    .out_val(res_val[0]), .out_data(res_data[0])
  );

  // Pure delay registers, depth from the cfg header
  for (genvar i = 0; i < n_delay; i++) begin : g_delay
    muldiv_pipe_reg #(.payload_t(muldiv_resp_pkg::result_t)) i_dly_reg (
      .clk(clk), .reset(reset), .hold(stall),
      .in_val(res_val[i]), .in_data(res_data[i]),
      .out_val(res_val[i+1]), .out_data(res_data[i+1])
    );
  end

  assign resp_val    = res_val[n_delay];
  assign resp_result = res_data[n_delay];

endmodule

/* verif/tb_clk_gen.sv */
// ------------------------------
// Free running clock, active low reset
// Reset releases on a rising edge
// ------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Held low for reset_cycles edges
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b1;
  end

endmodule

/* verif/muldiv_pipe_asserts.sv */
// ------------------------------
// Handshake and stall properties, bound into muldiv_pipe
// n_fail counts failed assertions
// ------------------------------

`timescale 1ns/1ps

module muldiv_pipe_asserts (
  input logic                     clk,
  input logic                     reset,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input muldiv_resp_pkg::result_t resp_result
);

  logic stall;
  int   n_fail = 0;

  // Output held by the consumer
  assign stall = resp_val && !resp_rdy;

  // ------------------------------
  // Properties
  // ------------------------------

  // Held response keeps valid and data
  a_hold_resp: assert property (
    @(posedge clk) disable iff (!reset) stall |=> resp_val && $stable(resp_result)
  ) else begin
    $error("resp_result or resp_val changed while stalled");
    n_fail++;
  end

  // Reset empties the output stage
  a_reset_empty: assert property (@(posedge clk) !reset |=> !resp_val)
    else begin
      $error("resp_val high after a reset edge");
      n_fail++;
    end

  // No unknown bits on a valid response
  a_known_resp: assert property (
    @(posedge clk) disable iff (!reset) resp_val |-> !$isunknown(resp_result)
  ) else begin
    $error("resp_result has unknown bits while valid");
    n_fail++;
  end

endmodule

bind muldiv_pipe muldiv_pipe_asserts i_asserts (
  .clk(clk), .reset(reset),
  .resp_val(resp_val), .resp_rdy(resp_rdy), .resp_result(resp_result)
);

/* verif/tb_muldiv_pipe.sv */
// ------------------------------
// Directed table, then LCG random requests under back-pressure
// Reference model assumes MULDIV_XLEN of 32
// ------------------------------

`timescale 1ns/1ps

`include "muldiv_cfg.svh"

module tb_muldiv_pipe;

  typedef logic [`MULDIV_XLEN-1:0] word_t;

  // One directed entry
  typedef struct {
    muldiv_req_pkg::fn_e      fn;
    word_t                    a;
    word_t                    b;
    muldiv_resp_pkg::result_t exp;
  } vec_t;

  localparam int     n_vec      = 17;
  localparam int     n_rand     = 300;
  localparam int     lat        = `MULDIV_LATENCY;
  localparam longint timeout_ns = longint'(n_vec + n_rand) * (lat + 8) * 20 * 4;
  localparam word_t  min_int    = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};
  localparam logic [31:0] seed  = 32'heae2e157;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  muldiv_req_pkg::fn_e      req_fn;
  word_t                    req_a;
  word_t                    req_b;
  logic                     resp_val;
  logic                     resp_rdy;
  muldiv_resp_pkg::result_t resp_result;

  vec_t                     vec_tab [$];
  // Pending requests, oldest first
  muldiv_resp_pkg::result_t exp_q   [$];
  int                       edge_q  [$];
  bit                       lat_q   [$];

  int          n_edge = 0;
  int          n_sent = 0;
  int          n_rcv  = 0;
  logic [31:0] stim_state;
  logic [31:0] bp_state;
  logic        rand_phase = 1'b0;

  tb_clk_gen #(.period_ns(20), .reset_cycles(10)) i_clk_gen (.clk(clk), .reset(reset));

  muldiv_pipe i_muldiv_pipe (
    .clk(clk), .reset(reset),
    .req_val(req_val), .req_rdy(req_rdy),
    .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp_result(resp_result)
  );

  always @(posedge clk) n_edge <= n_edge + 1;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected result straight from the RISC-V rules
  function automatic muldiv_resp_pkg::result_t ref_model(input muldiv_req_pkg::fn_e fn,
                                                         input word_t a, input word_t b);
    int                       ia;
    int                       ib;
    longint                   sa;
    longint                   sb;
    word_t                    q;
    word_t                    r;
    muldiv_resp_pkg::result_t res;
    ia  = a;
    ib  = b;
    sa  = ia;
    sb  = ib;
    res = '0;
    case (fn)
      muldiv_req_pkg::MUL: res = sa * sb;
      muldiv_req_pkg::DIV, muldiv_req_pkg::REM: begin
        if (b == '0) begin
          q = '1;
          r = a;
        end else if (a == min_int && b == '1) begin
          q = a;
          r = '0;
        end else begin
          // SV truncates, remainder follows the dividend
          q = ia / ib;
          r = ia % ib;
        end
        res.hi = r;
        res.lo = q;
      end
      muldiv_req_pkg::DIVU, muldiv_req_pkg::REMU: begin
        q = (b == '0) ? '1 : a / b;
        r = (b == '0) ? a : a % b;
        res.hi = r;
        res.lo = q;
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic report_failure();
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_result(input string name, input muldiv_resp_pkg::result_t exp,
                              input muldiv_resp_pkg::result_t act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%016h, got 0x%016h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      $display("** Error: latency expected 0x%0h, got 0x%0h", exp, act);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic add_vec(input muldiv_req_pkg::fn_e fn, input word_t a, input word_t b,
                         input word_t hi, input word_t lo);
    vec_t v;
    v.fn     = fn;
    v.a      = a;
    v.b      = b;
    v.exp.hi = hi;
    v.exp.lo = lo;
    vec_tab.push_back(v);
  endtask

  // Columns: function, a, b, expected hi, expected lo
  task automatic fill_table();
    add_vec(muldiv_req_pkg::MUL,  32'h00000007, 32'hfffffffd, 32'hffffffff, 32'hffffffeb);
    add_vec(muldiv_req_pkg::MUL,  32'h00000000, 32'h12345678, 32'h00000000, 32'h00000000);
    add_vec(muldiv_req_pkg::MUL,  32'h80000000, 32'h80000000, 32'h40000000, 32'h00000000);
    add_vec(muldiv_req_pkg::MUL,  32'h7fffffff, 32'h80000000, 32'hc0000000, 32'h80000000);
    add_vec(muldiv_req_pkg::MUL,  32'hffffffff, 32'hffffffff, 32'h00000000, 32'h00000001);
    add_vec(muldiv_req_pkg::DIV,  32'hfffffff9, 32'h00000002, 32'hffffffff, 32'hfffffffd);
    add_vec(muldiv_req_pkg::REM,  32'h00000007, 32'hfffffffe, 32'h00000001, 32'hfffffffd);
    add_vec(muldiv_req_pkg::DIV,  32'h00000064, 32'h00000007, 32'h00000002, 32'h0000000e);
    add_vec(muldiv_req_pkg::REM,  32'hffffff9c, 32'hfffffff9, 32'hfffffffe, 32'h0000000e);
    add_vec(muldiv_req_pkg::DIVU, 32'hfffffffe, 32'h00000002, 32'h00000000, 32'h7fffffff);
    add_vec(muldiv_req_pkg::REMU, 32'h80000001, 32'h00000010, 32'h00000001, 32'h08000000);
    add_vec(muldiv_req_pkg::DIVU, 32'h00000005, 32'h80000000, 32'h00000005, 32'h00000000);
    // Divide by zero, signed and unsigned
    add_vec(muldiv_req_pkg::DIV,  32'h12345678, 32'h00000000, 32'h12345678, 32'hffffffff);
    add_vec(muldiv_req_pkg::DIVU, 32'h80000000, 32'h00000000, 32'h80000000, 32'hffffffff);
    // min_int / -1
    add_vec(muldiv_req_pkg::REM,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000);
    // Codes 5 and 7
    add_vec(muldiv_req_pkg::fn_e'(3'd5), 32'h00001234, 32'h00005678, 32'h0, 32'h0);
    add_vec(muldiv_req_pkg::fn_e'(3'd7), 32'hffffffff, 32'h00000001, 32'h0, 32'h0);
  endtask

  task automatic gen_random(output muldiv_req_pkg::fn_e fn, output word_t a, output word_t b);
    logic [3:0] kind;
    stim_state = lcg_next(stim_state);
    fn         = muldiv_req_pkg::fn_e'(stim_state[31:29]);
    kind       = stim_state[27:24];
    stim_state = lcg_next(stim_state);
    a          = stim_state;
    stim_state = lcg_next(stim_state);
    b          = stim_state;
    // Steer some draws onto corner cases
    case (kind)
      4'd0: b = '0;
      4'd1: begin
        a = min_int;
        b = '1;
      end
      4'd2: b = b >> 28;
      4'd3: a = a >> 20;
      default: ;
    endcase
  endtask

  // Drive on a rising edge, hold until the accept edge
  task automatic send_req(input muldiv_req_pkg::fn_e fn, input word_t a, input word_t b,
                          input muldiv_resp_pkg::result_t exp, input bit chk_lat);
    @(posedge clk);
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    do @(negedge clk); while (!req_rdy);
    exp_q.push_back(exp);
    edge_q.push_back(n_edge + 1);
    lat_q.push_back(chk_lat);
    n_sent++;
  endtask

  // Stop requesting and wait for every response
  task automatic end_burst();
    @(posedge clk);
    req_val <= 1'b0;
    while (n_rcv < n_sent) @(posedge clk);
  endtask

  // ------------------------------
  // Back-pressure
  // ------------------------------

  initial begin : backpressure
    resp_rdy = 1'b1;
    bp_state = ~seed;
    forever begin
      @(posedge clk);
      bp_state = lcg_next(bp_state);
      // About 3 of 4 cycles ready in the random phase
      resp_rdy <= rand_phase ? (bp_state[31] | bp_state[30]) : 1'b1;
    end
  end

  // ------------------------------
  // Response monitor
  // ------------------------------

  initial begin : monitor
    muldiv_resp_pkg::result_t held;
    muldiv_resp_pkg::result_t exp;
    logic                     was_stalled;
    int                       acc_edge;
    bit                       lat_on;
    was_stalled = 1'b0;
    held        = '0;
    forever begin
      @(negedge clk);
      if (reset) begin
        check_flag("req_rdy", !(resp_val && !resp_rdy), req_rdy);
        if (was_stalled) begin
          check_flag("resp_val", 1'b1, resp_val);
          check_result("resp_result", held, resp_result);
        end
        if (i_muldiv_pipe.i_asserts.n_fail != 0) begin
          $display("A concurrent assertion on muldiv_pipe failed");
          report_failure();
        end
        if (resp_val && resp_rdy) begin
          if (exp_q.size() == 0) begin
            $display("Response arrived with no request pending");
            report_failure();
          end
          exp      = exp_q.pop_front();
          acc_edge = edge_q.pop_front();
          lat_on   = lat_q.pop_front();
          check_result("resp_result", exp, resp_result);
          if (lat_on) check_latency(lat, n_edge - acc_edge);
          n_rcv++;
        end
        was_stalled = resp_val && !resp_rdy;
        held        = resp_result;
      end
    end
  end

  // ------------------------------
  // Watchdog and main sequence
  // ------------------------------

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout after %0d ns, responses stopped arriving", timeout_ns);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    muldiv_req_pkg::fn_e fn;
    word_t               a;
    word_t               b;
    req_val    = 1'b0;
    req_fn     = muldiv_req_pkg::MUL;
    req_a      = '0;
    req_b      = '0;
    stim_state = seed;
    fill_table();
    while (!reset) @(negedge clk);
    // Empty pipe right after reset
    check_flag("resp_val", 1'b0, resp_val);
    check_flag("req_rdy", 1'b1, req_rdy);

    // Directed table, output never held so latency is exact
    foreach (vec_tab[i]) begin
      send_req(vec_tab[i].fn, vec_tab[i].a, vec_tab[i].b, vec_tab[i].exp, 1'b1);
    end
    end_burst();

    // Random requests with resp_rdy toggling
    @(negedge clk);
    rand_phase = 1'b1;
    for (int i = 0; i < n_rand; i++) begin
      gen_random(fn, a, b);
      send_req(fn, a, b, ref_model(fn, a, b), 1'b0);
    end
    end_burst();

    // Any late extra response trips the monitor here
    repeat (lat + 4) @(posedge clk);
    if (n_rcv == n_sent && exp_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Got %0d responses for %0d requests", n_rcv, n_sent);
      $display("Verification failed");
      $fatal(1, "response count mismatch");
    end
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/muldiv_req_pkg.sv
verilog/muldiv_resp_pkg.sv
verilog/muldiv_pipe_reg.sv
verilog/muldiv_opnd_prep.sv
verilog/muldiv_arith.sv
verilog/muldiv_pipe.sv
verif/tb_clk_gen.sv
verif/muldiv_pipe_asserts.sv
verif/tb_muldiv_pipe.sv

/* Bender.yml */
package:
  name: muldiv_pipe

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/muldiv_req_pkg.sv
      - verilog/muldiv_resp_pkg.sv
      - verilog/muldiv_pipe_reg.sv
      - verilog/muldiv_opnd_prep.sv
      - verilog/muldiv_arith.sv
      - verilog/muldiv_pipe.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clk_gen.sv
      - verif/muldiv_pipe_asserts.sv
      - verif/tb_muldiv_pipe.sv
